//--- all.f
source/ahb_mtx_pkg.sv
source/ahb_mtx_arbiter.sv
source/ahb_mtx_addr_mux.sv
source/ahb_mtx_data_phase.sv
source/ahb_mtx_output_stage.sv
verif/tb_ahb_mtx_output_stage.sv

//--- source/ahb_mtx_addr_mux.sv
// AHB bus matrix address-phase mux
// Routes the address and control of the granted port to the shared slave
// and decodes the one-hot active vector returned to the input stages

`default_nettype none

module ahb_mtx_addr_mux #(
  parameter  int NUM_PORTS = 4,                            // Competing input ports
  localparam int PORT_W    = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  wire ahb_mtx_pkg::ahb_cmd_t i_cmd [NUM_PORTS],    // Per-port commands
  input  wire [PORT_W-1:0]           i_port,               // Granted port index
  input  wire                        i_no_port,            // No port granted
  output ahb_mtx_pkg::ahb_cmd_t      o_cmd,                // Slave command
  output logic [NUM_PORTS-1:0]       o_active              // Port owns address phase
);

  // --------------------------------------------------------------------------
  // Command select and active decode
  // --------------------------------------------------------------------------
  // With no owner the slave sees an all-zero command, which is sel low and
  // an IDLE transfer
  always_comb
  begin : p_addr_mux
    o_cmd    = '0;
    o_active = '0;
    if (!i_no_port)
    begin
      o_cmd            = i_cmd[i_port];
      o_cmd.held_tran  = 1'b0;                   // Stays inside the matrix
      o_active[i_port] = 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Assertions
  // --------------------------------------------------------------------------
  // A granted index from the arbiter must land on a real port
  always_comb
  begin : p_active_check
    a_active_onehot : assert final ($onehot0(o_active) &&
                                    ((i_no_port !== 1'b0) || $onehot(o_active)));
  end

endmodule

`default_nettype wire

//--- source/ahb_mtx_arbiter.sv
// AHB bus matrix round-robin arbiter for one shared slave
// Picks the input port that owns the slave address phase. The grant is held
// through locked sequences and through bursts seen as BUSY or SEQ, and it
// only moves on a completing cycle of the shared slave

`default_nettype none

module ahb_mtx_arbiter #(
  parameter  int NUM_PORTS = 4,                            // Competing input ports
  localparam int PORT_W    = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  wire                        HCLK,                 // AHB system clock
  input  wire                        HRESETn,              // Synchronous reset
  input  wire ahb_mtx_pkg::ahb_cmd_t i_cmd [NUM_PORTS],    // Per-port commands
  input  wire ahb_mtx_pkg::ahb_cmd_t i_sel_cmd,            // Current owner command
  input  wire                        i_hready,             // HREADYMUXM
  output logic [PORT_W-1:0]          o_port,               // Granted port index
  output logic                       o_no_port             // No port granted
);

  import ahb_mtx_pkg::*;

  logic [NUM_PORTS-1:0] req;             // Per-port request
  logic                 any_req;         // At least one request
  logic [PORT_W-1:0]    next_port;       // Round-robin winner
  logic                 hsel_lock;       // Lock seen while sel dropped
  logic                 next_hsel_lock;  // Next hsel_lock
  logic                 hold_lock;       // Locked sequence in progress
  logic                 hold_burst;      // Burst in progress

  // --------------------------------------------------------------------------
  // Requests and round-robin search
  // --------------------------------------------------------------------------
  always_comb
  begin : p_req
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      req[p] = i_cmd[p].sel & i_cmd[p].held_tran;  // Only held transfers count
    end
  end

  // Search upward from the port after the last owner. The loop runs from the
  // farthest candidate down so the nearest requester is written last
  always_comb
  begin : p_rr_search
    int cand;
    cand      = 0;
    next_port = o_port;                          // Default keeps the index
    any_req   = 1'b0;
    for (int off = NUM_PORTS; off >= 1; off--)
    begin
      cand = int'(o_port) + off;
      if (cand >= NUM_PORTS)
      begin
        cand = cand - NUM_PORTS;                 // Wrap around
      end
      if (req[cand])
      begin
        next_port = PORT_W'(cand);
        any_req   = 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Grant hold
  // --------------------------------------------------------------------------
  // A master may leave this slave in the middle of a locked sequence, so sel
  // drops while mastlock stays up. hsel_lock remembers that the sequence
  // started here and keeps the slave reserved for it
  assign next_hsel_lock = (i_sel_cmd.sel & i_sel_cmd.trans[1] & i_sel_cmd.mastlock) ? 1'b1 :
                          (!i_sel_cmd.mastlock)                                     ? 1'b0 :
                          hsel_lock;

  assign hold_lock  = i_sel_cmd.mastlock & (i_sel_cmd.sel | hsel_lock);
  assign hold_burst = i_sel_cmd.sel &
                      ((i_sel_cmd.trans == TRANS_BUSY) | (i_sel_cmd.trans == TRANS_SEQ));

  // --------------------------------------------------------------------------
  // Grant registers
  // --------------------------------------------------------------------------
  always_ff @(posedge HCLK)
  begin : p_grant
    if (!HRESETn)
    begin
      o_port    <= PORT_W'(NUM_PORTS - 1);       // Port 0 gets first turn
      o_no_port <= 1'b1;
      hsel_lock <= 1'b0;
    end
    else if (i_hready)                           // Completing cycle only
    begin
      hsel_lock <= next_hsel_lock;
      if (hold_lock | hold_burst)
      begin
        o_port    <= o_port;                     // Owner keeps the slave
        o_no_port <= o_no_port;
      end
      else if (any_req)
      begin
        o_port    <= next_port;
        o_no_port <= 1'b0;
      end
      else
      begin
        o_no_port <= 1'b1;                       // Index kept as last owner
      end
    end
  end

  // --------------------------------------------------------------------------
  // Assertions
  // --------------------------------------------------------------------------
  // Wait states from the slave freeze the owner
  a_port_stable_wait : assert property (@(posedge HCLK) disable iff (!HRESETn)
    !i_hready |=> $stable(o_port));

  // A locked sequence seen through the address mux keeps its port granted
  a_port_stable_lock : assert property (@(posedge HCLK) disable iff (!HRESETn)
    hold_lock |=> ($stable(o_port) && !o_no_port));

endmodule

`default_nettype wire

//--- source/ahb_mtx_data_phase.sv
// AHB bus matrix data-phase stage
// Registers the address-phase owner on each completing cycle so that its
// write data reaches the slave one phase later, and forms HREADYMUXM from
// the slave HREADYOUT while the slave is selected

`default_nettype none

module ahb_mtx_data_phase #(
  parameter  int NUM_PORTS = 4,                            // Competing input ports
  localparam int PORT_W    = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  wire                         HCLK,                // AHB system clock
  input  wire                         HRESETn,             // Synchronous reset
  input  wire [PORT_W-1:0]            i_port,              // Address-phase owner
  input  wire                         i_hsel,              // Selected sel
  input  wire ahb_mtx_pkg::ahb_data_t i_wdata [NUM_PORTS], // Per-port write data
  input  wire                         i_hreadyoutm,        // Slave HREADYOUT
  output ahb_mtx_pkg::ahb_data_t      o_hwdatam,           // Slave write data
  output logic                        o_hreadymuxm         // Slave HREADY
);

  logic [PORT_W-1:0] data_port;  // Data-phase owner
  logic              slave_sel;  // Slave selected in data phase

  // --------------------------------------------------------------------------
  // Address to data phase registers
  // --------------------------------------------------------------------------
  always_ff @(posedge HCLK)
  begin : p_data_port
    if (!HRESETn)
    begin
      data_port <= '0;
      slave_sel <= 1'b0;                         // HREADYMUXM high out of reset
    end
    else if (o_hreadymuxm)                       // Address phase completes
    begin
      data_port <= i_port;
      slave_sel <= i_hsel;
    end
  end

  // --------------------------------------------------------------------------
  // Write data mux
  // --------------------------------------------------------------------------
  assign o_hwdatam = i_wdata[data_port];         // Follows data-phase owner

  // --------------------------------------------------------------------------
  // HREADYMUXM generation
  // --------------------------------------------------------------------------
  // An unselected slave never stretches the bus, so only a data phase that
  // belongs to this slave can insert wait states
  assign o_hreadymuxm = slave_sel ? i_hreadyoutm : 1'b1;

endmodule

`default_nettype wire

//--- source/ahb_mtx_output_stage.sv
// AHB bus matrix output stage for one shared slave
// Up to NUM_PORTS input stages compete for the slave. The arbiter picks the
// address-phase owner, the address mux routes its command and the data
// phase follows with the owner's write data one completing cycle later

`default_nettype none

module ahb_mtx_output_stage #(
  parameter  int NUM_PORTS = 4,                            // Competing input ports
  localparam int PORT_W    = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  wire                         HCLK,                // AHB system clock
  input  wire                         HRESETn,             // Synchronous reset
  input  wire ahb_mtx_pkg::ahb_cmd_t  i_cmd [NUM_PORTS],   // Per-port commands
  input  wire ahb_mtx_pkg::ahb_data_t i_wdata [NUM_PORTS], // Per-port write data
  input  wire                         i_hreadyoutm,        // Slave HREADYOUT
  output wire ahb_mtx_pkg::ahb_cmd_t  o_cmd,               // Slave command
  output wire [NUM_PORTS-1:0]         o_active,            // Port owns address phase
  output wire ahb_mtx_pkg::ahb_data_t o_hwdatam,           // Slave write data
  output wire                         o_hreadymuxm         // Slave HREADY
);

  wire [PORT_W-1:0] addr_port;     // Registered grant index
  wire              addr_no_port;  // No port granted

  // --------------------------------------------------------------------------
  // Arbitration
  // --------------------------------------------------------------------------
  ahb_mtx_arbiter #(
    .NUM_PORTS (NUM_PORTS)
  ) u_arbiter (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .i_cmd     (i_cmd),
    .i_sel_cmd (o_cmd),                          // Owner command for hold logic
    .i_hready  (o_hreadymuxm),
    .o_port    (addr_port),
    .o_no_port (addr_no_port)
  );

  // --------------------------------------------------------------------------
  // Address phase
  // --------------------------------------------------------------------------
  ahb_mtx_addr_mux #(
    .NUM_PORTS (NUM_PORTS)
  ) u_addr_mux (
    .i_cmd     (i_cmd),
    .i_port    (addr_port),
    .i_no_port (addr_no_port),
    .o_cmd     (o_cmd),
    .o_active  (o_active)
  );

  // --------------------------------------------------------------------------
  // Data phase
  // --------------------------------------------------------------------------
  ahb_mtx_data_phase #(
    .NUM_PORTS (NUM_PORTS)
  ) u_data_phase (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_port       (addr_port),
    .i_hsel       (o_cmd.sel),                   // Zero when nobody is granted
    .i_wdata      (i_wdata),
    .i_hreadyoutm (i_hreadyoutm),
    .o_hwdatam    (o_hwdatam),
    .o_hreadymuxm (o_hreadymuxm)
  );

endmodule

`default_nettype wire

//--- source/ahb_mtx_pkg.sv
// AHB bus matrix output stage shared definitions
// Bus widths, the HTRANS encoding and the address-phase command that each
// input port presents to the shared slave output stage

`default_nettype none

package ahb_mtx_pkg;

  // --------------------------------------------------------------------------
  // Bus widths
  // --------------------------------------------------------------------------
  localparam int ADDR_W = 32;                  // HADDR width
  localparam int DATA_W = 32;                  // HWDATA width

  typedef logic [ADDR_W-1:0] ahb_addr_t;       // Address bus
  typedef logic [DATA_W-1:0] ahb_data_t;       // Write data bus
  typedef logic [2:0]        ahb_size_t;       // HSIZE
  typedef logic [3:0]        ahb_prot_t;       // HPROT
  typedef logic [3:0]        ahb_master_t;     // HMASTER

  // --------------------------------------------------------------------------
  // Transfer type
  // --------------------------------------------------------------------------
  typedef enum logic [1:0] {
    TRANS_IDLE   = 2'b00,                      // No transfer
    TRANS_BUSY   = 2'b01,                      // Burst paused by master
    TRANS_NONSEQ = 2'b10,                      // First beat or single
    TRANS_SEQ    = 2'b11                       // Following burst beat
  } ahb_trans_e;

  // --------------------------------------------------------------------------
  // Address-phase command of one input port
  // --------------------------------------------------------------------------
  // held_tran comes from the input stage holding register and only matters
  // for arbitration, it is never passed on to the slave
  typedef struct packed {
    logic        sel;                          // HSEL for this slave
    ahb_addr_t   addr;                         // HADDR
    ahb_trans_e  trans;                        // HTRANS
    logic        write;                        // HWRITE
    ahb_size_t   size;                         // HSIZE
    ahb_prot_t   prot;                         // HPROT
    ahb_master_t master;                       // HMASTER
    logic        mastlock;                     // HMASTLOCK
    logic        held_tran;                    // Transfer held in input stage
  } ahb_cmd_t;

endpackage

`default_nettype wire

//--- verif/tb_ahb_mtx_output_stage.sv
// Testbench for the AHB bus matrix output stage
// Drives four input ports and the slave HREADYOUT, keeps a cycle model of
// the grant, lock and data-phase state and compares every DUT output on
// each clock cycle against that model

`default_nettype none

module tb_ahb_mtx_output_stage;

  timeunit 1ns;
  timeprecision 100ps;

  import ahb_mtx_pkg::*;

  localparam int NUM_PORTS  = 4;
  localparam int MAX_CYCLES = 2000;              // About twice the test length

  typedef struct packed {
    logic [1:0] port;                            // Granted index
    logic       no_port;                         // Nobody granted
  } grant_t;

  logic      hclk;
  logic      hresetn;
  ahb_cmd_t  cmd   [NUM_PORTS];                  // Port commands
  ahb_data_t wdata [NUM_PORTS];                  // Port write data
  logic      hreadyoutm;                         // Slave ready

  wire ahb_cmd_t             dut_cmd;
  wire [NUM_PORTS-1:0]       dut_active;
  wire ahb_data_t            dut_hwdatam;
  wire                       dut_hreadymuxm;

  grant_t      m_grant;                          // Model arbiter state
  logic        m_lock;                           // Model held-select lock
  logic [1:0]  m_data_port;                      // Model data-phase owner
  logic        m_slave_sel;                      // Model data-phase select
  logic        m_valid;                          // Model seen a reset
  integer      seed;
  int          cycle_cnt;

  ahb_mtx_output_stage #(
    .NUM_PORTS (NUM_PORTS)
  ) dut0 (
    .HCLK         (hclk),
    .HRESETn      (hresetn),
    .i_cmd        (cmd),
    .i_wdata      (wdata),
    .i_hreadyoutm (hreadyoutm),
    .o_cmd        (dut_cmd),
    .o_active     (dut_active),
    .o_hwdatam    (dut_hwdatam),
    .o_hreadymuxm (dut_hreadymuxm)
  );

  initial
  begin : p_clock
    hclk = 1'b0;
    forever #5 hclk = ~hclk;                     // 10 ns period
  end

  // ------------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------------
  // Command the slave sees for a given grant
  function automatic ahb_cmd_t owner_cmd(input grant_t g);
    ahb_cmd_t c;
    c = '0;
    if (!g.no_port)
    begin
      c           = cmd[g.port];
      c.held_tran = 1'b0;                        // Never leaves the matrix
    end
    return c;
  endfunction

  // Next grant from requests, owner command and lock state
  function automatic grant_t next_grant(input logic [NUM_PORTS-1:0] req,
                                        input ahb_cmd_t sel_cmd,
                                        input grant_t cur,
                                        input logic lock);
    grant_t nxt;
    int     cand;
    logic   hold;
    nxt  = cur;
    cand = 0;
    hold = (sel_cmd.mastlock && (sel_cmd.sel || lock)) ||
           (sel_cmd.sel && ((sel_cmd.trans == TRANS_BUSY) || (sel_cmd.trans == TRANS_SEQ)));
    if (!hold)
    begin
      nxt.no_port = 1'b1;                        // Index stays if nobody asks
      for (int off = 1; off <= NUM_PORTS; off++)
      begin
        cand = (int'(cur.port) + off) % NUM_PORTS;   // Upward with wrap
        if (req[cand] && nxt.no_port)
        begin
          nxt.port    = cand[1:0];
          nxt.no_port = 1'b0;
        end
      end
    end
    return nxt;
  endfunction

  // Advance the model by one rising edge
  task automatic update_model();
    ahb_cmd_t             sel_cmd;
    grant_t               cur;
    logic [NUM_PORTS-1:0] req;
    logic                 hready;
    cur     = m_grant;
    sel_cmd = owner_cmd(cur);
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      req[p] = cmd[p].sel & cmd[p].held_tran;
    end
    hready = m_slave_sel ? hreadyoutm : 1'b1;
    if (!hresetn)
    begin
      m_grant     = '{port: 2'd3, no_port: 1'b1};   // Port 0 goes first
      m_lock      = 1'b0;
      m_data_port = 2'd0;
      m_slave_sel = 1'b0;
      m_valid     = 1'b1;
    end
    else if (m_valid && (hready === 1'b1))       // Completing cycle only
    begin
      m_grant = next_grant(req, sel_cmd, cur, m_lock);
      if (sel_cmd.sel && sel_cmd.trans[1] && sel_cmd.mastlock)
      begin
        m_lock = 1'b1;
      end
      else if (!sel_cmd.mastlock)
      begin
        m_lock = 1'b0;
      end
      m_data_port = cur.port;                    // Address owner moves to data
      m_slave_sel = sel_cmd.sel;
    end
  endtask

  // ------------------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------------------
  task automatic check_cmd(input string name, input ahb_cmd_t got, input ahb_cmd_t exp);
    if (got !== exp)
    begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_data(input string name, input ahb_data_t got, input ahb_data_t exp);
    if (got !== exp)
    begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      $display("Test failed");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic compare_outputs();
    ahb_cmd_t             exp_cmd;
    logic [NUM_PORTS-1:0] exp_active;
    exp_cmd    = owner_cmd(m_grant);
    exp_active = '0;
    if (!m_grant.no_port)
    begin
      exp_active[m_grant.port] = 1'b1;           // One-hot owner
    end
    check_cmd("o_cmd", dut_cmd, exp_cmd);
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      check_bit($sformatf("o_active[%0d]", p), dut_active[p], exp_active[p]);
    end
    check_data("o_hwdatam", dut_hwdatam, wdata[m_data_port]);
    check_bit("o_hreadymuxm", dut_hreadymuxm, m_slave_sel ? hreadyoutm : 1'b1);
  endtask

  // Model steps on the edge, outputs compared half a ns later
  initial
  begin : p_check
    m_valid = 1'b0;
    forever
    begin
      @(posedge hclk);
      update_model();
      #0.5;
      if (m_valid)
      begin
        compare_outputs();
      end
    end
  end

  initial
  begin : p_timeout
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES)
    begin
      @(posedge hclk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, the stimulus never reached its end", cycle_cnt);
    $display("Test failed");
    $fatal(1, "cycle limit reached");
  end

  // ------------------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------------------
  task automatic step();
    @(posedge hclk);
    #1;                                          // Inputs change after the edge
  endtask

  function automatic ahb_cmd_t make_cmd(input int port, input ahb_trans_e trans,
                                        input logic sel, input logic lock);
    ahb_cmd_t c;
    c           = '0;
    c.sel       = sel;
    c.addr      = $random(seed);
    c.trans     = trans;
    c.write     = 1'b1;
    c.size      = 3'b010;                        // Word
    c.prot      = 4'b0011;
    c.master    = port[3:0];
    c.mastlock  = lock;
    c.held_tran = sel;
    return c;
  endfunction

  function automatic ahb_cmd_t random_cmd(input int port);
    ahb_cmd_t    c;
    logic [31:0] r;
    r           = $random(seed);
    c           = make_cmd(port, ahb_trans_e'(r[1:0]), r[2] | r[3], r[6:4] == 3'b000);
    c.held_tran = c.sel & (r[7] | r[8]);         // Mostly held when selected
    c.write     = r[9];
    return c;
  endfunction

  task automatic idle_ports();
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      cmd[p] = '0;
    end
  endtask

  task automatic request_all();
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      cmd[p] = make_cmd(p, TRANS_NONSEQ, 1'b1, 1'b0);
    end
  endtask

  // Random write data and about one wait state in four
  task automatic randomize_data_ready();
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      wdata[p] = $random(seed);
    end
    hreadyoutm = (($random(seed) & 3) != 0);
  endtask

  task automatic apply_reset();
    hresetn = 1'b0;
    step();
    step();
    hresetn = 1'b1;
  endtask

  task automatic wait_grant(input int p);
    step();
    while (dut_active[p] !== 1'b1)
    begin
      step();
    end
  endtask

  // ------------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------------
  initial
  begin : p_stimulus
    ahb_cmd_t exp;
    seed       = 3337;
    hresetn    = 1'b0;
    hreadyoutm = 1'b1;
    idle_ports();
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      wdata[p] = 32'hD0D0_0000 | p;
    end
    apply_reset();

    // Reset state
    check_cmd("o_cmd", dut_cmd, '0);
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      check_bit($sformatf("o_active[%0d]", p), dut_active[p], 1'b0);
    end
    check_bit("o_hreadymuxm", dut_hreadymuxm, 1'b1);

    // Single requester on port 2
    cmd[2] = make_cmd(2, TRANS_NONSEQ, 1'b1, 1'b0);
    for (int k = 0; k < 6; k++)
    begin
      step();
      exp           = cmd[2];
      exp.held_tran = 1'b0;
      check_cmd("o_cmd", dut_cmd, exp);
      check_bit("o_active[2]", dut_active[2], 1'b1);
      cmd[2] = make_cmd(2, TRANS_NONSEQ, 1'b1, 1'b0);   // Next single transfer
    end

    // Round robin from a fresh reset
    apply_reset();
    request_all();
    for (int k = 0; k < 9; k++)
    begin
      step();
      check_bit($sformatf("o_active[%0d]", k % 4), dut_active[k % 4], 1'b1);
      request_all();
    end

    // Locked port keeps the slave while its sel drops
    idle_ports();
    request_all();
    cmd[1] = make_cmd(1, TRANS_NONSEQ, 1'b1, 1'b1);
    wait_grant(1);
    cmd[1] = make_cmd(1, TRANS_NONSEQ, 1'b1, 1'b1);     // Locked beat sets the lock
    step();
    check_bit("o_active[1]", dut_active[1], 1'b1);
    cmd[1] = make_cmd(1, TRANS_IDLE, 1'b0, 1'b1);       // Away but still locked
    repeat (2)
    begin
      step();
      check_bit("o_active[1]", dut_active[1], 1'b1);
    end
    cmd[1] = '0;                                        // Lock released
    step();
    check_bit("o_active[2]", dut_active[2], 1'b1);

    // Burst on port 3 held through SEQ and BUSY
    cmd[3] = make_cmd(3, TRANS_NONSEQ, 1'b1, 1'b0);
    wait_grant(3);
    cmd[3] = make_cmd(3, TRANS_SEQ, 1'b1, 1'b0);
    step();
    check_bit("o_active[3]", dut_active[3], 1'b1);
    cmd[3] = make_cmd(3, TRANS_BUSY, 1'b1, 1'b0);
    step();
    check_bit("o_active[3]", dut_active[3], 1'b1);
    cmd[3] = make_cmd(3, TRANS_SEQ, 1'b1, 1'b0);
    step();
    check_bit("o_active[3]", dut_active[3], 1'b1);
    cmd[3] = '0;                                        // Burst done
    step();
    check_bit("o_active[0]", dut_active[0], 1'b1);

    // Data phase with random wait states, ports 0 and 2 alternating
    idle_ports();
    repeat (150)
    begin
      cmd[0] = make_cmd(0, TRANS_NONSEQ, 1'b1, 1'b0);
      cmd[2] = make_cmd(2, TRANS_NONSEQ, 1'b1, 1'b0);
      randomize_data_ready();
      step();
    end

    // Random traffic on all ports
    repeat (800)
    begin
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        cmd[p] = random_cmd(p);
      end
      randomize_data_ready();
      step();
    end

    idle_ports();
    hreadyoutm = 1'b1;
    step();
    step();
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
